/* src.f */
hdl/pkt_sched_pkg.sv
hdl/queue_store.sv
hdl/sched_arbiter.sv
hdl/egress_port.sv
hdl/pkt_sched_top.sv
test/pkt_sched_chk.sv
test/pkt_sched_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pkt_sched_tb \
    -f src.f -o pkt_sched_sim

out=$(./obj_dir/pkt_sched_sim +verilator+error+limit+1000) || true
echo "$out"
echo "$out" | grep -qx "sim passed"

/* test/pkt_sched_tb.sv */
//////////////////////////////////////////////////////////////////////
// Scheduler testbench with directed tests, per-queue scoreboard and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pkt_sched_tb;

    localparam int          CLK_PERIOD   = 40;
    localparam logic [31:0] SEED         = 32'h132efad2;
    localparam int          RAND_PKTS    = 200;
    localparam int          SHAPER_DEC   = 8;
    localparam int          ETH_OVERHEAD = 20;
    localparam int          NP  = pkt_sched_pkg::NUM_PORTS;
    localparam int          NQ  = pkt_sched_pkg::NUM_QUEUES;
    localparam int          QPP = pkt_sched_pkg::QUEUES_PER_PORT;
    localparam int          WB  = pkt_sched_pkg::WORD_BYTES;

    logic                       core_clk_ifc;
    logic                       rst_n;
    logic                       enq_valid;
    pkt_sched_pkg::queue_id_t   enq_queue;
    pkt_sched_pkg::blen_t       enq_blen;
    logic                       enq_ready;
    logic [NP-1:0]              out_valid;
    logic [NP-1:0]              out_ready;
    logic [NP-1:0]              out_last;
    pkt_sched_pkg::word_bytes_t out_bytes [NP];
    pkt_sched_pkg::prio_t       out_prio [NP];

    // Expected words for each DUT queue
    pkt_sched_pkg::word_bytes_t exp_bytes [NQ][$];
    logic                       exp_last [NQ][$];
    int                         exp_total [NQ];
    int                         got_total [NQ];
    pkt_sched_pkg::prio_t       prio_log [NP][$];
    int                         first_cyc [NP];
    int                         last_cyc [NP];

    int          cyc = 0;
    int          enq_words = 0;
    int          check_errors = 0;
    int          other_errors = 0;
    logic [31:0] rng_state;

    pkt_sched_top #(
        .QUEUE_DEPTH  ( 8            ),
        .BUF_DEPTH    ( 8            ),
        .SHAPER_DEC   ( SHAPER_DEC   ),
        .ETH_OVERHEAD ( ETH_OVERHEAD )
    ) i_dut (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .enq_valid    ( enq_valid    ),
        .enq_queue    ( enq_queue    ),
        .enq_blen     ( enq_blen     ),
        .enq_ready    ( enq_ready    ),
        .out_valid    ( out_valid    ),
        .out_ready    ( out_ready    ),
        .out_last     ( out_last     ),
        .out_bytes    ( out_bytes    ),
        .out_prio     ( out_prio     )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_bytes(pkt_sched_pkg::word_bytes_t got,
                               pkt_sched_pkg::word_bytes_t exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_last(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_prio(pkt_sched_pkg::prio_t got, pkt_sched_pkg::prio_t exp, string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            check_errors++;
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Output monitor checking every transfer against the scoreboard

    always @(negedge core_clk_ifc) begin
        int q;
        for (int p = 0; p < NP; p++) begin
            if (rst_n && out_valid[p] && out_ready[p]) begin
                q = p * QPP + int'(out_prio[p]);
                if (first_cyc[p] < 0) begin
                    first_cyc[p] = cyc;
                end
                last_cyc[p] = cyc;
                prio_log[p].push_back(out_prio[p]);
                got_total[q] += int'(out_bytes[p]);
                if (exp_bytes[q].size() == 0) begin
                    $display("Unexpected word on port %0d queue %0d at %0t", p, q, $time);
                    other_errors++;
                end else begin
                    check_bytes(out_bytes[p], exp_bytes[q].pop_front(),
                                $sformatf("port %0d queue %0d bytes", p, q));
                    check_last(out_last[p], exp_last[q].pop_front(),
                               $sformatf("port %0d queue %0d last", p, q));
                end
            end
        end
    end

    // Segments the packet into expected words, then hands it to the DUT
    task automatic enqueue(int q, int len);
        int rem;
        rem = len;
        while (rem > WB) begin
            exp_bytes[q].push_back(pkt_sched_pkg::word_bytes_t'(WB));
            exp_last[q].push_back(1'b0);
            rem -= WB;
            enq_words++;
        end
        exp_bytes[q].push_back(pkt_sched_pkg::word_bytes_t'(rem));
        exp_last[q].push_back(1'b1);
        enq_words++;
        exp_total[q] += len;
        @(posedge core_clk_ifc);
        enq_valid <= 1'b1;
        enq_queue <= pkt_sched_pkg::queue_id_t'(q);
        enq_blen  <= pkt_sched_pkg::blen_t'(len);
        do @(negedge core_clk_ifc); while (!enq_ready);
        @(posedge core_clk_ifc);
        enq_valid <= 1'b0;
    endtask

    function automatic int port_pending(int p);
        int n;
        n = 0;
        for (int r = 0; r < QPP; r++) begin
            n += exp_bytes[p * QPP + r].size();
        end
        return n;
    endfunction

    task automatic wait_port_drain(int p);
        while (port_pending(p) != 0) @(negedge core_clk_ifc);
    endtask

    task automatic wait_drain();
        for (int p = 0; p < NP; p++) begin
            wait_port_drain(p);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_segmentation();
        enqueue(0, 64);
        enqueue(0, 65);
        enqueue(0, 128);
        enqueue(0, 1500);
        wait_drain();
    endtask

    task automatic test_strict_priority();
        pkt_sched_pkg::prio_t exp_prio;
        @(posedge core_clk_ifc);
        out_ready[1] <= 1'b0;
        prio_log[1].delete();
        enqueue(4, 1500);
        repeat (20) @(posedge core_clk_ifc);
        enqueue(6, 200);
        enqueue(7, 200);
        @(posedge core_clk_ifc);
        out_ready[1] <= 1'b1;
        wait_drain();
        // 24 words of the locked packet then 4 each for priorities 3 and 2
        check_count(prio_log[1].size(), 32, "port 1 word count");
        for (int i = 0; i < prio_log[1].size(); i++) begin
            exp_prio = (i < 24) ? 2'd0 : (i < 28) ? 2'd3 : 2'd2;
            check_prio(prio_log[1][i], exp_prio, $sformatf("port 1 word %0d priority", i));
        end
    endtask

    task automatic test_port_isolation();
        @(posedge core_clk_ifc);
        out_ready[2] <= 1'b0;
        enqueue(9, 300);
        enqueue(1, 500);
        enqueue(14, 700);
        enqueue(11, 150);
        enqueue(3, 200);
        enqueue(12, 100);
        wait_port_drain(0);
        wait_port_drain(3);
        // Stalled port still presents its head word
        check_count(int'(out_valid[2]), 1, "port 2 out_valid while stalled");
        @(posedge core_clk_ifc);
        out_ready[2] <= 1'b1;
        wait_drain();
    endtask

    task automatic test_random_traffic();
        int q;
        int len;
        for (int i = 0; i < RAND_PKTS; i++) begin
            q   = int'(xorshift_next() % NQ);
            len = pkt_sched_pkg::MIN_BYTES
                  + int'(xorshift_next() % (pkt_sched_pkg::MTU_BYTES - pkt_sched_pkg::MIN_BYTES + 1));
            enqueue(q, len);
        end
        wait_drain();
        for (int k = 0; k < NQ; k++) begin
            check_count(got_total[k], exp_total[k], $sformatf("queue %0d total bytes", k));
        end
    endtask

    task automatic test_shaper_pacing();
        int min_cycles;
        first_cyc[3] = -1;
        for (int i = 0; i < 10; i++) begin
            enqueue(13, 1000);
        end
        wait_drain();
        // All packets but the last must have drained through the shaper
        min_cycles = (9 * (1000 + ETH_OVERHEAD)) / SHAPER_DEC;
        if (last_cyc[3] - first_cyc[3] < min_cycles) begin
            $display("CHECK FAILED at %0t: shaped span %0d cycles, at least %0d expected",
                     $time, last_cyc[3] - first_cyc[3], min_cycles);
            check_errors++;
        end
    endtask

    // Budget of 200 cycles per enqueued word
    initial begin
        @(posedge core_clk_ifc);
        while (cyc <= 100 + 200 * enq_words) begin
            @(posedge core_clk_ifc);
        end
        $display("Timeout: DUT stopped delivering words at cycle %0d", cyc);
        $display("Errors: %0d check, %0d other", check_errors, other_errors);
        $display("sim failed");
        $finish;
    end

    initial begin
        rng_state = SEED;
        rst_n     = 1'b0;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_blen  = '0;
        out_ready = '1;
        for (int p = 0; p < NP; p++) begin
            first_cyc[p] = -1;
            last_cyc[p]  = 0;
        end
        for (int q = 0; q < NQ; q++) begin
            exp_total[q] = 0;
            got_total[q] = 0;
        end
        repeat (10) @(posedge core_clk_ifc);
        rst_n <= 1'b1;
        repeat (2) @(posedge core_clk_ifc);
        test_segmentation();
        test_strict_priority();
        test_port_isolation();
        test_random_traffic();
        test_shaper_pacing();
        repeat (20) @(posedge core_clk_ifc);
        $display("Errors: %0d check, %0d other, %0d assertion",
                 check_errors, other_errors, i_dut.i_chk.fail_count);
        if (check_errors + other_errors + i_dut.i_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* test/pkt_sched_chk.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the scheduler handshakes, bound to the top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pkt_sched_chk (
    input logic                                core_clk_ifc,
    input logic                                rst_n,
    input logic [pkt_sched_pkg::NUM_PORTS-1:0] out_valid,
    input logic [pkt_sched_pkg::NUM_PORTS-1:0] out_ready,
    input logic [pkt_sched_pkg::NUM_PORTS-1:0] out_last,
    input pkt_sched_pkg::word_bytes_t          out_bytes [pkt_sched_pkg::NUM_PORTS],
    input pkt_sched_pkg::prio_t                out_prio [pkt_sched_pkg::NUM_PORTS],
    input logic                                deq_req_valid,
    input pkt_sched_pkg::queue_id_t            deq_req_queue,
    input logic                                note_valid,
    input pkt_sched_pkg::queue_id_t            note_queue
);

    localparam int NP = pkt_sched_pkg::NUM_PORTS;
    localparam int HI = pkt_sched_pkg::QID_W - 1;
    localparam int PW = pkt_sched_pkg::PORT_W;

    int fail_count = 0;

    // Request state per port as seen on the store interface
    pkt_sched_pkg::port_state_e req_state [NP];

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NP; p++) begin
                req_state[p] <= pkt_sched_pkg::PORT_IDLE;
            end
        end else begin
            if (note_valid) begin
                req_state[note_queue[HI -: PW]] <= pkt_sched_pkg::PORT_IDLE;
            end
            if (deq_req_valid) begin
                req_state[deq_req_queue[HI -: PW]] <= pkt_sched_pkg::PORT_WAIT;
            end
        end
    end

    a_req_idle: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        deq_req_valid |-> req_state[deq_req_queue[HI -: PW]] == pkt_sched_pkg::PORT_IDLE)
        else begin
            fail_count++;
            $error("dequeue request to a port that is still waiting");
        end

    a_reset_quiet: assert property (@(posedge core_clk_ifc)
        !rst_n |-> (out_valid == '0) && !deq_req_valid && !note_valid)
        else begin
            fail_count++;
            $error("valid signal high during reset");
        end

    ///////////////////////////////////////////////////////////////////////
    // Output words hold until they transfer

    for (genvar p = 0; p < NP; p++) begin : g_port
        a_out_hold: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_bytes[p])
                && $stable(out_last[p]) && $stable(out_prio[p]))
            else begin
                fail_count++;
                $error("port %0d dropped or changed its word before transfer", p);
            end
    end

endmodule

bind pkt_sched_top pkt_sched_chk i_chk (
    .core_clk_ifc  ( core_clk_ifc  ),
    .rst_n         ( rst_n         ),
    .out_valid     ( out_valid     ),
    .out_ready     ( out_ready     ),
    .out_last      ( out_last      ),
    .out_bytes     ( out_bytes     ),
    .out_prio      ( out_prio      ),
    .deq_req_valid ( deq_req_valid ),
    .deq_req_queue ( deq_req_queue ),
    .note_valid    ( note_valid    ),
    .note_queue    ( note_queue    )
);

/* hdl/pkt_sched_top.sv */
//////////////////////////////////////////////////////////////////////
// Scheduler top level: queue store, arbiter and the egress ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pkt_sched_top #(
    parameter int QUEUE_DEPTH  = 8,
    parameter int BUF_DEPTH    = 8,
    parameter int SHAPER_DEC   = 8,
    parameter int ETH_OVERHEAD = 20
) (
    input  logic                              core_clk_ifc,
    input  logic                              rst_n,
    input  logic                              enq_valid,
    input  pkt_sched_pkg::queue_id_t          enq_queue,
    input  pkt_sched_pkg::blen_t              enq_blen,
    output logic                              enq_ready,
    output logic [pkt_sched_pkg::NUM_PORTS-1:0] out_valid,
    input  logic [pkt_sched_pkg::NUM_PORTS-1:0] out_ready,
    output logic [pkt_sched_pkg::NUM_PORTS-1:0] out_last,
    output pkt_sched_pkg::word_bytes_t        out_bytes [pkt_sched_pkg::NUM_PORTS],
    output pkt_sched_pkg::prio_t              out_prio [pkt_sched_pkg::NUM_PORTS]
);

    logic [pkt_sched_pkg::NUM_QUEUES-1:0] queue_empty;
    logic [pkt_sched_pkg::NUM_PORTS-1:0]  egr_ready;

    logic                       deq_req_valid;
    pkt_sched_pkg::queue_id_t   deq_req_queue;

    logic                       note_valid;
    pkt_sched_pkg::queue_id_t   note_queue;
    pkt_sched_pkg::word_bytes_t note_bytes;
    logic                       note_last;

    queue_store #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) i_queue_store (
        .core_clk_ifc  ( core_clk_ifc  ),
        .rst_n         ( rst_n         ),
        .enq_valid     ( enq_valid     ),
        .enq_queue     ( enq_queue     ),
        .enq_blen      ( enq_blen      ),
        .enq_ready     ( enq_ready     ),
        .queue_empty   ( queue_empty   ),
        .deq_req_valid ( deq_req_valid ),
        .deq_req_queue ( deq_req_queue ),
        .note_valid    ( note_valid    ),
        .note_queue    ( note_queue    ),
        .note_bytes    ( note_bytes    ),
        .note_last     ( note_last     )
    );

    sched_arbiter i_sched_arbiter (
        .core_clk_ifc  ( core_clk_ifc  ),
        .rst_n         ( rst_n         ),
        .queue_empty   ( queue_empty   ),
        .egr_ready     ( egr_ready     ),
        .note_valid    ( note_valid    ),
        .note_queue    ( note_queue    ),
        .note_last     ( note_last     ),
        .deq_req_valid ( deq_req_valid ),
        .deq_req_queue ( deq_req_queue )
    );

    // One egress port per port, each filtering the shared notification
    for (genvar p = 0; p < pkt_sched_pkg::NUM_PORTS; p++) begin : g_egress
        egress_port #(
            .BUF_DEPTH    ( BUF_DEPTH    ),
            .SHAPER_DEC   ( SHAPER_DEC   ),
            .ETH_OVERHEAD ( ETH_OVERHEAD ),
            .PORT_NUM     ( p            )
        ) i_egress_port (
            .core_clk_ifc ( core_clk_ifc ),
            .rst_n        ( rst_n        ),
            .note_valid   ( note_valid   ),
            .note_queue   ( note_queue   ),
            .note_bytes   ( note_bytes   ),
            .note_last    ( note_last    ),
            .egr_ready    ( egr_ready[p] ),
            .out_valid    ( out_valid[p] ),
            .out_bytes    ( out_bytes[p] ),
            .out_last     ( out_last[p]  ),
            .out_prio     ( out_prio[p]  ),
            .out_ready    ( out_ready[p] )
        );
    end

endmodule

/* hdl/egress_port.sv */
//////////////////////////////////////////////////////////////////////
// Egress port: word buffer, fill-level ready and byte shaper
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module egress_port #(
    parameter int BUF_DEPTH    = 8,
    parameter int SHAPER_DEC   = 8,
    parameter int ETH_OVERHEAD = 20,
    parameter int PORT_NUM     = 0
) (
    input  logic                       core_clk_ifc,
    input  logic                       rst_n,
    input  logic                       note_valid,
    input  pkt_sched_pkg::queue_id_t   note_queue,
    input  pkt_sched_pkg::word_bytes_t note_bytes,
    input  logic                       note_last,
    output logic                       egr_ready,
    output logic                       out_valid,
    output pkt_sched_pkg::word_bytes_t out_bytes,
    output logic                       out_last,
    output pkt_sched_pkg::prio_t       out_prio,
    input  logic                       out_ready
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int ACC_W = 16;

    pkt_sched_pkg::word_bytes_t buf_bytes [BUF_DEPTH];
    logic                       buf_last  [BUF_DEPTH];
    pkt_sched_pkg::prio_t       buf_prio  [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic wr_en;
    logic rd_en;

    logic signed [ACC_W-1:0] shaper_acc;
    logic signed [ACC_W-1:0] charge;

    // Keep only notifications addressed to this port
    assign wr_en = note_valid && (note_queue[pkt_sched_pkg::QID_W-1 -: pkt_sched_pkg::PORT_W]
                                  == pkt_sched_pkg::port_id_t'(PORT_NUM));
    assign rd_en = out_valid && out_ready;

    // Two slots of headroom cover the requests still in flight
    assign egr_ready = count <= CNT_W'(BUF_DEPTH - 2);

    assign out_valid = (count != '0) && shaper_acc[ACC_W-1];
    assign out_bytes = buf_bytes[rd_ptr];
    assign out_last  = buf_last[rd_ptr];
    assign out_prio  = buf_prio[rd_ptr];

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            buf_bytes[wr_ptr] <= note_bytes;
            buf_last[wr_ptr]  <= note_last;
            buf_prio[wr_ptr]  <= note_queue[pkt_sched_pkg::PRIO_W-1:0];
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Byte shaper

    // Word bytes, plus line overhead once per packet
    assign charge = ACC_W'(out_bytes) + (out_last ? ACC_W'(ETH_OVERHEAD) : '0);

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            shaper_acc <= -1;
        end else if (rd_en) begin
            shaper_acc <= shaper_acc + charge - ACC_W'(SHAPER_DEC);
        end else if (!shaper_acc[ACC_W-1]) begin
            // Drains while in debt, holds once credit is available
            shaper_acc <= shaper_acc - ACC_W'(SHAPER_DEC);
        end
    end

endmodule

/* hdl/sched_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Strict-priority queue pick per port, round-robin port grant
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sched_arbiter (
    input  logic                                 core_clk_ifc,
    input  logic                                 rst_n,
    input  logic [pkt_sched_pkg::NUM_QUEUES-1:0] queue_empty,
    input  logic [pkt_sched_pkg::NUM_PORTS-1:0]  egr_ready,
    input  logic                                 note_valid,
    input  pkt_sched_pkg::queue_id_t             note_queue,
    input  logic                                 note_last,
    output logic                                 deq_req_valid,
    output pkt_sched_pkg::queue_id_t             deq_req_queue
);

    localparam int NP  = pkt_sched_pkg::NUM_PORTS;
    localparam int QPP = pkt_sched_pkg::QUEUES_PER_PORT;

    pkt_sched_pkg::port_state_e port_state [NP];
    logic [NP-1:0]              locked;
    pkt_sched_pkg::prio_t       lock_prio [NP];
    // Last granted port
    pkt_sched_pkg::port_id_t    rr_ptr;

    logic [NP-1:0]           eligible;
    pkt_sched_pkg::prio_t    pick_prio [NP];
    logic                    grant_valid;
    pkt_sched_pkg::port_id_t grant_port;
    pkt_sched_pkg::port_id_t note_port;

    assign note_port = note_queue[pkt_sched_pkg::QID_W-1 -: pkt_sched_pkg::PORT_W];

    ///////////////////////////////////////////////////////////////////////
    // Queue choice within each port

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            pick_prio[p] = '0;
            // Ascending scan, so the highest non-empty queue wins
            for (int q = 0; q < QPP; q++) begin
                if (!queue_empty[p*QPP + q]) begin
                    pick_prio[p] = pkt_sched_pkg::prio_t'(q);
                end
            end
            if (locked[p]) begin
                pick_prio[p] = lock_prio[p];
            end
            eligible[p] = (port_state[p] == pkt_sched_pkg::PORT_IDLE) && egr_ready[p]
                          && !(&queue_empty[p*QPP +: QPP]);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Round-robin grant starting after rr_ptr

    always_comb begin
        pkt_sched_pkg::port_id_t cand;
        grant_valid = 1'b0;
        grant_port  = rr_ptr;
        // Descending scan, the nearest eligible port is written last
        for (int i = NP; i >= 1; i--) begin
            cand = pkt_sched_pkg::port_id_t'((int'(rr_ptr) + i) % NP);
            if (eligible[cand]) begin
                grant_valid = 1'b1;
                grant_port  = cand;
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            deq_req_valid <= 1'b0;
            rr_ptr        <= pkt_sched_pkg::port_id_t'(NP - 1);
            locked        <= '0;
            for (int p = 0; p < NP; p++) begin
                port_state[p] <= pkt_sched_pkg::PORT_IDLE;
            end
        end else begin
            deq_req_valid <= grant_valid;
            if (grant_valid) begin
                rr_ptr                 <= grant_port;
                port_state[grant_port] <= pkt_sched_pkg::PORT_WAIT;
                locked[grant_port]     <= 1'b1;
            end
            // A waiting port is never granted, so no clash with the grant above
            if (note_valid) begin
                port_state[note_port] <= pkt_sched_pkg::PORT_IDLE;
                if (note_last) begin
                    locked[note_port] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (grant_valid) begin
            deq_req_queue         <= {grant_port, pick_prio[grant_port]};
            lock_prio[grant_port] <= pick_prio[grant_port];
        end
    end

endmodule

/* hdl/queue_store.sv */
//////////////////////////////////////////////////////////////////////
// Per-queue length FIFOs with head segmentation into words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module queue_store #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                 core_clk_ifc,
    input  logic                                 rst_n,
    input  logic                                 enq_valid,
    input  pkt_sched_pkg::queue_id_t             enq_queue,
    input  pkt_sched_pkg::blen_t                 enq_blen,
    output logic                                 enq_ready,
    output logic [pkt_sched_pkg::NUM_QUEUES-1:0] queue_empty,
    input  logic                                 deq_req_valid,
    input  pkt_sched_pkg::queue_id_t             deq_req_queue,
    output logic                                 note_valid,
    output pkt_sched_pkg::queue_id_t             note_queue,
    output pkt_sched_pkg::word_bytes_t           note_bytes,
    output logic                                 note_last
);

    localparam int NQ    = pkt_sched_pkg::NUM_QUEUES;
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    pkt_sched_pkg::blen_t len_mem [NQ][QUEUE_DEPTH];
    pkt_sched_pkg::blen_t rem_len [NQ];

    logic [PTR_W-1:0] wr_ptr  [NQ];
    logic [PTR_W-1:0] rd_ptr  [NQ];
    logic [CNT_W-1:0] count   [NQ];
    // Head packet already partly sent, so rem_len holds its remainder
    logic [NQ-1:0]    started;

    logic          enq_fire;
    logic [NQ-1:0] push_q;
    logic [NQ-1:0] pop_q;

    pkt_sched_pkg::blen_t head_len;

    // Stage one registers
    logic                       s1_valid;
    pkt_sched_pkg::queue_id_t   s1_queue;
    pkt_sched_pkg::word_bytes_t s1_bytes;
    logic                       s1_last;
    pkt_sched_pkg::blen_t       s1_rem;

    assign enq_ready = count[enq_queue] < CNT_W'(QUEUE_DEPTH);
    assign enq_fire  = enq_valid && enq_ready;

    always_comb begin
        for (int q = 0; q < NQ; q++) begin
            queue_empty[q] = (count[q] == '0);
            push_q[q]      = enq_fire && (enq_queue == pkt_sched_pkg::queue_id_t'(q));
            pop_q[q]       = s1_valid && s1_last && (s1_queue == pkt_sched_pkg::queue_id_t'(q));
        end
    end

    // Remaining bytes of the requested head packet
    assign head_len = started[deq_req_queue] ? rem_len[deq_req_queue]
                                             : len_mem[deq_req_queue][rd_ptr[deq_req_queue]];

    ///////////////////////////////////////////////////////////////////////
    // Pointers, counts and pipeline valids

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < NQ; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
            started    <= '0;
            s1_valid   <= 1'b0;
            note_valid <= 1'b0;
        end else begin
            s1_valid   <= deq_req_valid;
            note_valid <= s1_valid;
            for (int q = 0; q < NQ; q++) begin
                if (push_q[q]) begin
                    wr_ptr[q] <= (wr_ptr[q] == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr[q] + 1'b1;
                end
                if (pop_q[q]) begin
                    rd_ptr[q] <= (rd_ptr[q] == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr[q] + 1'b1;
                end
                count[q] <= count[q] + CNT_W'(push_q[q]) - CNT_W'(pop_q[q]);
            end
            // Stage two: pop on the last word, otherwise keep the remainder
            if (s1_valid) begin
                started[s1_queue] <= !s1_last;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Length storage and word payload

    always_ff @(posedge core_clk_ifc) begin
        if (enq_fire) begin
            len_mem[enq_queue][wr_ptr[enq_queue]] <= enq_blen;
        end

        // Stage one: word size and last flag for the head packet
        s1_queue <= deq_req_queue;
        s1_last  <= head_len <= pkt_sched_pkg::BLEN_W'(pkt_sched_pkg::WORD_BYTES);
        s1_rem   <= head_len - pkt_sched_pkg::BLEN_W'(pkt_sched_pkg::WORD_BYTES);
        if (head_len <= pkt_sched_pkg::BLEN_W'(pkt_sched_pkg::WORD_BYTES)) begin
            s1_bytes <= pkt_sched_pkg::word_bytes_t'(head_len);
        end else begin
            s1_bytes <= pkt_sched_pkg::word_bytes_t'(pkt_sched_pkg::WORD_BYTES);
        end

        if (s1_valid && !s1_last) begin
            rem_len[s1_queue] <= s1_rem;
        end
        note_queue <= s1_queue;
        note_bytes <= s1_bytes;
        note_last  <= s1_last;
    end

endmodule

/* hdl/pkt_sched_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Scheduler topology constants, shared field types, port state enum
//////////////////////////////////////////////////////////////////////

package pkt_sched_pkg;

    // Topology
    localparam int NUM_PORTS       = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = NUM_PORTS * QUEUES_PER_PORT;

    // Packet and word sizes in bytes
    localparam int WORD_BYTES = 64;
    localparam int MTU_BYTES  = 1500;
    localparam int MIN_BYTES  = 64;

    localparam int PORT_W  = $clog2(NUM_PORTS);
    localparam int PRIO_W  = $clog2(QUEUES_PER_PORT);
    localparam int QID_W   = PORT_W + PRIO_W;
    localparam int BLEN_W  = $clog2(MTU_BYTES + 1);
    localparam int WBYTE_W = $clog2(WORD_BYTES + 1);

    typedef logic [PORT_W-1:0]  port_id_t;
    // Higher value wins
    typedef logic [PRIO_W-1:0]  prio_t;
    // Port in the upper bits, priority in the lower bits
    typedef logic [QID_W-1:0]   queue_id_t;
    typedef logic [BLEN_W-1:0]  blen_t;
    typedef logic [WBYTE_W-1:0] word_bytes_t;

    typedef enum logic {
        PORT_IDLE,
        PORT_WAIT
    } port_state_e;

endpackage
